/* Bender.yml */
package:
  name: sv32_mmu

sources:
  # RTL, package first
  - source/sv32_pkg.sv
  - source/tlb_way.sv
  - source/sv32_tlb.sv
  - source/sv32_table_walk.sv
  - source/sv32_mmu.sv

  # testbench
  - target: simulation
    files:
      - tb/pt_mem_model.sv
      - tb/sv32_mmu_assert.sv
      - tb/tb_sv32_mmu.sv

/* sim.f */
source/sv32_pkg.sv
source/tlb_way.sv
source/sv32_tlb.sv
source/sv32_table_walk.sv
source/sv32_mmu.sv
tb/pt_mem_model.sv
tb/sv32_mmu_assert.sv
tb/tb_sv32_mmu.sv

/* source/sv32_mmu.sv */
// Sv32 MMU top: walker plus separate instruction and data TLBs
// flush_i only while no request is open, it clears both TLBs
module sv32_mmu (
  input  logic                 clk,
  input  logic                 resetn,
  input  sv32_pkg::mmu_req_t   req_i,
  input  logic                 valid_i,
  input  sv32_pkg::sv32_satp_t satp_i,
  input  logic                 flush_i,
  output logic                 ready_o,
  output sv32_pkg::sv32_pte_t  pte_o,
  output logic                 mem_valid_o,
  output logic [31:0]          mem_addr_o,
  input  logic                 mem_ready_i,
  input  sv32_pkg::sv32_pte_t  mem_rdata_i
);

  import sv32_pkg::*;

  // walker to tlb controls
  logic      itlb_lookup;
  logic      dtlb_lookup;
  logic      itlb_fill;
  logic      dtlb_fill;
  sv32_pte_t fill_pte;

  // tlb answers
  logic      itlb_hit;
  logic      dtlb_hit;
  sv32_pte_t itlb_pte;
  sv32_pte_t dtlb_pte;

  sv32_table_walk walk_inst (
    .clk           (clk),
    .resetn        (resetn),
    .req_i         (req_i),
    .valid_i       (valid_i),
    .satp_i        (satp_i),
    .ready_o       (ready_o),
    .pte_o         (pte_o),
    .itlb_lookup_o (itlb_lookup),
    .dtlb_lookup_o (dtlb_lookup),
    .itlb_fill_o   (itlb_fill),
    .dtlb_fill_o   (dtlb_fill),
    .fill_pte_o    (fill_pte),
    .itlb_hit_i    (itlb_hit),
    .dtlb_hit_i    (dtlb_hit),
    .itlb_pte_i    (itlb_pte),
    .dtlb_pte_i    (dtlb_pte),
    .mem_valid_o   (mem_valid_o),
    .mem_addr_o    (mem_addr_o),
    .mem_ready_i   (mem_ready_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  // both tlbs see the same address, the walker gates which one acts
  sv32_tlb itlb_inst (
    .clk        (clk),
    .resetn     (resetn),
    .flush_i    (flush_i),
    .lookup_i   (itlb_lookup),
    .fill_i     (itlb_fill),
    .va_i       (req_i.vaddr),
    .fill_pte_i (fill_pte),
    .hit_o      (itlb_hit),
    .pte_o      (itlb_pte)
  );

  sv32_tlb dtlb_inst (
    .clk        (clk),
    .resetn     (resetn),
    .flush_i    (flush_i),
    .lookup_i   (dtlb_lookup),
    .fill_i     (dtlb_fill),
    .va_i       (req_i.vaddr),
    .fill_pte_i (fill_pte),
    .hit_o      (dtlb_hit),
    .pte_o      (dtlb_pte)
  );

endmodule

/* source/sv32_pkg.sv */
// Sv32 field types, request and TLB entry layouts, TLB geometry
// TLB_WAYS must be a power of two so the round-robin pointer wraps cleanly
// physical addresses are cut to 32 bits, asid is carried but never compared
package sv32_pkg;

  // tlb geometry
  localparam int TLB_ENTRIES = 16;
  localparam int TLB_WAYS = 4;
  localparam int TLB_SETS = TLB_ENTRIES / TLB_WAYS;
  localparam int TLB_SET_BITS = $clog2(TLB_SETS);
  localparam int TLB_WAY_BITS = $clog2(TLB_WAYS);
  // page number bits left above the set index
  localparam int TLB_TAG_BITS = 20 - TLB_SET_BITS;

  // pte flag byte, msb first
  typedef struct packed {
    logic d;
    logic a;
    logic g;
    logic u;
    logic x;
    logic w;
    logic r;
    logic v;
  } sv32_flags_t;

  // leaf or pointer pte, also the translation result
  typedef struct packed {
    logic [11:0] ppn1;
    logic [9:0]  ppn0;
    logic [1:0]  rsw;
    sv32_flags_t flags;
  } sv32_pte_t;

  // walker view of a virtual address
  typedef struct packed {
    logic [9:0]  vpn1;
    logic [9:0]  vpn0;
    logic [11:0] offset;
  } sv32_va_walk_t;

  // tlb view, whole page number as tag
  typedef struct packed {
    logic [19:0] tag;
    logic [11:0] offset;
  } sv32_va_tlb_t;

  typedef union packed {
    sv32_va_walk_t walk;
    sv32_va_tlb_t  tlb;
  } sv32_va_u;

  typedef struct packed {
    logic        mode;
    logic [8:0]  asid;
    logic [21:0] ppn;
  } sv32_satp_t;

  typedef struct packed {
    sv32_va_u vaddr;
    logic     is_instr;
  } mmu_req_t;

  // one way slot
  typedef struct packed {
    logic                    valid;
    logic [TLB_TAG_BITS-1:0] tag;
    sv32_pte_t               pte;
  } tlb_entry_t;

endpackage

/* source/sv32_table_walk.sv */
// Sv32 translation FSM: bare mode, TLB lookup, two-level walk, TLB fill
// req_i and satp_i must stay stable until ready_o, one request at a time
// no permission, A/D or superpage alignment checks; a fault returns pte 0
// table bases keep only the low 20 ppn bits, so page tables sit below 4 GiB
module sv32_table_walk (
  input  logic                 clk,
  input  logic                 resetn,
  input  sv32_pkg::mmu_req_t   req_i,
  input  logic                 valid_i,
  input  sv32_pkg::sv32_satp_t satp_i,
  output logic                 ready_o,
  output sv32_pkg::sv32_pte_t  pte_o,
  output logic                 itlb_lookup_o,
  output logic                 dtlb_lookup_o,
  output logic                 itlb_fill_o,
  output logic                 dtlb_fill_o,
  output sv32_pkg::sv32_pte_t  fill_pte_o,
  input  logic                 itlb_hit_i,
  input  logic                 dtlb_hit_i,
  input  sv32_pkg::sv32_pte_t  itlb_pte_i,
  input  sv32_pkg::sv32_pte_t  dtlb_pte_i,
  output logic                 mem_valid_o,
  output logic [31:0]          mem_addr_o,
  input  logic                 mem_ready_i,
  input  sv32_pkg::sv32_pte_t  mem_rdata_i
);

  import sv32_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_FETCH
  } walk_state_e;

  walk_state_e state_q;
  walk_state_e state_d;

  // 1 while reading the root table, 0 for the second level
  logic        level_q;
  logic        level_d;

  // byte address of the table being read
  logic [31:0] base_q;
  logic [31:0] base_d;

  logic        ready_d;
  sv32_pte_t   pte_d;

  // tlb answer for the side this request belongs to
  logic        tlb_hit;
  sv32_pte_t   tlb_pte;

  // walk helpers
  logic [9:0]  vpn_idx;
  logic        is_pointer;
  logic        is_leaf;
  logic        leaf_done;
  sv32_pte_t   leaf_pte;
  sv32_pte_t   bare_pte;

  assign tlb_hit = req_i.is_instr ? itlb_hit_i : dtlb_hit_i;
  assign tlb_pte = req_i.is_instr ? itlb_pte_i : dtlb_pte_i;

  // lookup only in its own cycle, and only toward one tlb
  assign itlb_lookup_o = (state_q == ST_LOOKUP) && req_i.is_instr;
  assign dtlb_lookup_o = (state_q == ST_LOOKUP) && !req_i.is_instr;

  // index into the current table
  assign vpn_idx = level_q ? req_i.vaddr.walk.vpn1 : req_i.vaddr.walk.vpn0;

  // base plus four bytes per pte
  assign mem_addr_o  = base_q + {20'b0, vpn_idx, 2'b00};
  assign mem_valid_o = (state_q == ST_FETCH);

  // pte classes
  assign is_pointer = mem_rdata_i.flags.v && !mem_rdata_i.flags.r &&
                      !mem_rdata_i.flags.w && !mem_rdata_i.flags.x;
  assign is_leaf    = mem_rdata_i.flags.v && !is_pointer;

  // leaf arrives this cycle
  assign leaf_done = (state_q == ST_FETCH) && mem_ready_i && is_leaf;

  always_comb begin
    leaf_pte     = mem_rdata_i;
    leaf_pte.rsw = '0;
    // megapage, low ppn comes from the address
    if (level_q) begin
      leaf_pte.ppn0 = req_i.vaddr.walk.vpn0;
    end
  end

  // identity mapping for bare mode
  always_comb begin
    bare_pte         = '0;
    bare_pte.ppn1    = {2'b00, req_i.vaddr.walk.vpn1};
    bare_pte.ppn0    = req_i.vaddr.walk.vpn0;
    bare_pte.flags.v = 1'b1;
    bare_pte.flags.r = 1'b1;
    bare_pte.flags.w = 1'b1;
    bare_pte.flags.x = 1'b1;
  end

  // fill goes to the tlb that missed
  assign fill_pte_o  = leaf_pte;
  assign itlb_fill_o = leaf_done && req_i.is_instr;
  assign dtlb_fill_o = leaf_done && !req_i.is_instr;

  always_comb begin
    state_d = state_q;
    level_d = level_q;
    base_d  = base_q;
    ready_d = 1'b0;
    pte_d   = pte_o;
    case (state_q)
      ST_IDLE: begin
        // ready_o still high means valid_i belongs to the answered request
        if (valid_i && !ready_o) begin
          if (satp_i.mode) begin
            state_d = ST_LOOKUP;
            level_d = 1'b1;
            base_d  = {satp_i.ppn[19:0], 12'h000};
          end else begin
            ready_d = 1'b1;
            pte_d   = bare_pte;
          end
        end
      end
      ST_LOOKUP: begin
        if (tlb_hit) begin
          state_d = ST_IDLE;
          ready_d = 1'b1;
          pte_d   = tlb_pte;
        end else begin
          state_d = ST_FETCH;
        end
      end
      ST_FETCH: begin
        // hold address and valid until the word comes back
        if (mem_ready_i) begin
          if (is_leaf) begin
            state_d = ST_IDLE;
            ready_d = 1'b1;
            pte_d   = leaf_pte;
          end else if (is_pointer && level_q) begin
            // descend to the second-level table
            level_d = 1'b0;
            base_d  = {mem_rdata_i.ppn1[9:0], mem_rdata_i.ppn0, 12'h000};
          end else begin
            // invalid pte or pointer at level 0
            state_d = ST_IDLE;
            ready_d = 1'b1;
            pte_d   = '0;
          end
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q <= ST_IDLE;
      level_q <= 1'b1;
      ready_o <= 1'b0;
    end else begin
      state_q <= state_d;
      level_q <= level_d;
      ready_o <= ready_d;
    end
  end

  // payload, loaded before it is read
  always_ff @(posedge clk) begin
    base_q <= base_d;
    pte_o  <= pte_d;
  end

endmodule

/* source/sv32_tlb.sv */
// set-associative TLB built from TLB_WAYS identical ways
// hit_o is only valid while lookup_i is high, in the same cycle
// victim is picked round robin per set, reset and flush restart every pointer
// a page is never filled twice, at most one way hits
module sv32_tlb (
  input  logic                clk,
  input  logic                resetn,
  input  logic                flush_i,
  input  logic                lookup_i,
  input  logic                fill_i,
  input  sv32_pkg::sv32_va_u  va_i,
  input  sv32_pkg::sv32_pte_t fill_pte_i,
  output logic                hit_o,
  output sv32_pkg::sv32_pte_t pte_o
);

  import sv32_pkg::*;

  // address split
  logic [TLB_SET_BITS-1:0] set_idx;
  logic [TLB_TAG_BITS-1:0] set_tag;

  // per-way results
  logic [TLB_WAYS-1:0]     way_hit;
  logic [TLB_WAYS-1:0]     way_we;
  sv32_pte_t               way_pte [TLB_WAYS];

  // round-robin state, one pointer per set
  logic [TLB_WAY_BITS-1:0] rr_ptr [TLB_SETS];
  logic [TLB_WAY_BITS-1:0] victim;

  // low page number bits pick the set, the rest is stored as tag
  assign set_idx = va_i.tlb.tag[TLB_SET_BITS-1:0];
  assign set_tag = va_i.tlb.tag[19:TLB_SET_BITS];

  // next way to overwrite in this set
  assign victim = rr_ptr[set_idx];

  for (genvar w = 0; w < TLB_WAYS; w++) begin : g_way
    // only the victim way takes the fill
    assign way_we[w] = fill_i && (int'(victim) == w);

    tlb_way way_inst (
      .clk     (clk),
      .resetn  (resetn),
      .flush_i (flush_i),
      .set_i   (set_idx),
      .tag_i   (set_tag),
      .we_i    (way_we[w]),
      .wpte_i  (fill_pte_i),
      .hit_o   (way_hit[w]),
      .pte_o   (way_pte[w])
    );
  end

  // hit select
  assign hit_o = lookup_i && (|way_hit);

  always_comb begin
    pte_o = '0;
    // first hitting way wins, there is never more than one
    for (int w = TLB_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        pte_o = way_pte[w];
      end
    end
  end

  // victim pointer update
  always_ff @(posedge clk) begin
    if (!resetn || flush_i) begin
      for (int s = 0; s < TLB_SETS; s++) begin
        rr_ptr[s] <= '0;
      end
    end else if (fill_i) begin
      // wraps at TLB_WAYS
      rr_ptr[set_idx] <= victim + 1'b1;
    end
  end

endmodule

/* source/tlb_way.sv */
// one way of a set-associative TLB, one entry per set
// lookup is combinational, a write takes effect at the next clock edge
// flush and reset clear the valid bits only
module tlb_way (
  input  logic                              clk,
  input  logic                              resetn,
  input  logic                              flush_i,
  input  logic [sv32_pkg::TLB_SET_BITS-1:0] set_i,
  input  logic [sv32_pkg::TLB_TAG_BITS-1:0] tag_i,
  input  logic                              we_i,
  input  sv32_pkg::sv32_pte_t               wpte_i,
  output logic                              hit_o,
  output sv32_pkg::sv32_pte_t               pte_o
);

  import sv32_pkg::*;

  // entry storage, indexed by set
  tlb_entry_t entries [TLB_SETS];

  // entry currently addressed
  tlb_entry_t cur_entry;

  assign cur_entry = entries[set_i];

  // tag compare on the addressed set
  assign hit_o = cur_entry.valid && (cur_entry.tag == tag_i);

  // pte goes out unqualified, hit_o says if it counts
  assign pte_o = cur_entry.pte;

  always_ff @(posedge clk) begin
    if (!resetn || flush_i) begin
      // drop every entry at once
      for (int s = 0; s < TLB_SETS; s++) begin
        entries[s].valid <= 1'b0;
      end
    end else if (we_i) begin
      // fill overwrites whatever sat in this set
      entries[set_i].valid <= 1'b1;
      entries[set_i].tag   <= tag_i;
      entries[set_i].pte   <= wpte_i;
    end
  end

endmodule

/* tb/pt_mem_model.sv */
// page table memory for the walker, root table at 0x10000, level-0 table at 0x11000
// words outside both tables read as an address pattern with V clear
// a read completes 2 to 5 cycles after mem_valid_i, extra delay from $urandom
module pt_mem_model (
  input  logic                clk,
  input  logic                resetn,
  input  logic                mem_valid_i,
  input  logic [31:0]         mem_addr_i,
  output logic                mem_ready_o,
  output sv32_pkg::sv32_pte_t mem_rdata_o,
  output int                  read_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import sv32_pkg::*;

  localparam logic [31:0] TABLE_BASE  = 32'h0001_0000;
  localparam int          TABLE_WORDS = 2048;
  localparam int          DELAY_SLOTS = 64;

  logic [31:0] table_mem [TABLE_WORDS];
  logic [31:0] word_idx;
  logic        busy;
  logic [1:0]  wait_left;
  // extra delay per read, indexed by completed reads
  logic [1:0]  delay_tab [DELAY_SLOTS];

  // bit 0 is V, always clear here
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:2] ^ 30'h2AAA_AAAA, 2'b00};
  endfunction

  function automatic sv32_pte_t make_pte(input logic [11:0] ppn1, input logic [9:0] ppn0,
                                         input logic [7:0] flags);
    return {ppn1, ppn0, 2'b00, flags};
  endfunction

  initial begin
    void'($urandom(60));
    for (int i = 0; i < DELAY_SLOTS; i++) begin
      delay_tab[i] = 2'($urandom % 4);
    end
    for (int i = 0; i < TABLE_WORDS; i++) begin
      table_mem[i] = fill_word(TABLE_BASE + 32'(i) * 4);
    end
    // root: vpn1 1 points to level 0, vpn1 2 is a megapage, vpn1 3 invalid
    table_mem[1] = make_pte(12'h000, 10'h011, 8'h01);
    table_mem[2] = make_pte(12'h123, 10'h000, 8'hCF);
    table_mem[3] = make_pte(12'h345, 10'h067, 8'hCE);
    // level 0 leaves, vpn0 4 to 20 in steps of 4 all land in tlb set 0
    table_mem[1024 + 1] = make_pte(12'h0AB, 10'h101, 8'hCF);
    for (int v = 4; v <= 20; v += 4) begin
      table_mem[1024 + v] = make_pte(12'h0AB, 10'h100 + 10'(v), 8'hCF);
    end
    // pointer where a leaf is required
    table_mem[1024 + 32] = make_pte(12'h000, 10'h012, 8'h01);
  end

  // addresses below the base wrap to a huge index
  assign word_idx = (mem_addr_i - TABLE_BASE) >> 2;

  always_comb begin
    if (word_idx < TABLE_WORDS) begin
      mem_rdata_o = table_mem[word_idx[10:0]];
    end else begin
      mem_rdata_o = fill_word(mem_addr_i);
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      mem_ready_o  <= 1'b0;
      busy         <= 1'b0;
      wait_left    <= '0;
      read_count_o <= 0;
    end else begin
      mem_ready_o <= 1'b0;
      if (mem_valid_i && mem_ready_o) begin
        // word taken by the walker
        read_count_o <= read_count_o + 1;
      end else if (busy) begin
        if (wait_left == 2'd0) begin
          mem_ready_o <= 1'b1;
          busy        <= 1'b0;
        end else begin
          wait_left <= wait_left - 2'd1;
        end
      end else if (mem_valid_i) begin
        busy      <= 1'b1;
        wait_left <= delay_tab[read_count_o[5:0]];
      end
    end
  end

endmodule

/* tb/sv32_mmu_assert.sv */
// handshake checks on the walker, attached with bind
// fail_count is read by the testbench top
module sv32_mmu_assert (
  input logic        clk,
  input logic        resetn,
  input logic        ready_i,
  input logic        mem_valid_i,
  input logic [31:0] mem_addr_i,
  input logic        mem_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // read request held with a steady address until accepted
  mem_hold_a: assert property (@(posedge clk) disable iff (!resetn)
    mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_addr_i))
    else begin
      $error("mem_valid_o dropped or mem_addr_o moved before mem_ready_i");
      fail_count++;
    end

  // ready_o is a one-cycle pulse
  ready_pulse_a: assert property (@(posedge clk) disable iff (!resetn)
    ready_i |=> !ready_i)
    else begin
      $error("ready_o high for two cycles in a row");
      fail_count++;
    end

  // outputs idle right after a reset edge
  reset_idle_a: assert property (@(posedge clk) !resetn |=> !ready_i && !mem_valid_i)
    else begin
      $error("ready_o or mem_valid_o high after reset");
      fail_count++;
    end

endmodule

/* tb/tb_sv32_mmu.sv */
// testbench for sv32_mmu, table-driven requests against the page table in pt_mem_model
// one request at a time, inputs change on the falling edge, results checked at ready_o
// expected pte and read counts follow from that page table layout
module tb_sv32_mmu;

  timeunit 1ns;
  timeprecision 1ps;

  import sv32_pkg::*;

  localparam int          NUM_ROWS       = 16;
  localparam int          TIMEOUT_CYCLES = NUM_ROWS * 20 + 10;
  // root table sits at 0x10000
  localparam logic [21:0] ROOT_PPN       = 22'h00010;

  typedef struct packed {
    sv32_va_u   vaddr;
    logic       is_instr;
    logic       mode;
    logic       flush_first;
    sv32_pte_t  exp_pte;
    logic [3:0] exp_reads;
  } row_t;

  logic        clk;
  logic        resetn;
  mmu_req_t    req;
  logic        valid;
  sv32_satp_t  satp;
  logic        flush;
  logic        ready;
  sv32_pte_t   pte;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic        mem_ready;
  sv32_pte_t   mem_rdata;
  int          read_count;

  row_t        rows [NUM_ROWS];
  string       row_names [NUM_ROWS];
  int          n_rows;
  int          cycle_count;

  sv32_mmu sv32_mmu_inst (
    .clk         (clk),
    .resetn      (resetn),
    .req_i       (req),
    .valid_i     (valid),
    .satp_i      (satp),
    .flush_i     (flush),
    .ready_o     (ready),
    .pte_o       (pte),
    .mem_valid_o (mem_valid),
    .mem_addr_o  (mem_addr),
    .mem_ready_i (mem_ready),
    .mem_rdata_i (mem_rdata)
  );

  pt_mem_model mem_inst (
    .clk          (clk),
    .resetn       (resetn),
    .mem_valid_i  (mem_valid),
    .mem_addr_i   (mem_addr),
    .mem_ready_o  (mem_ready),
    .mem_rdata_o  (mem_rdata),
    .read_count_o (read_count)
  );

  bind sv32_table_walk sv32_mmu_assert handshake_assert_inst (
    .clk         (clk),
    .resetn      (resetn),
    .ready_i     (ready_o),
    .mem_valid_i (mem_valid_o),
    .mem_addr_i  (mem_addr_o),
    .mem_ready_i (mem_ready_i)
  );

  function automatic sv32_pte_t make_pte(input logic [11:0] ppn1, input logic [9:0] ppn0,
                                         input logic [7:0] flags);
    return {ppn1, ppn0, 2'b00, flags};
  endfunction

  // level-0 leaves map to ppn 0x0AB : 0x100 + vpn0
  function automatic sv32_pte_t leaf_4k(input logic [9:0] vpn0);
    return make_pte(12'h0AB, 10'h100 + vpn0, 8'hCF);
  endfunction

  task automatic add_row(input string name, input logic [9:0] vpn1, input logic [9:0] vpn0,
                         input logic is_instr, input logic mode, input logic flush_first,
                         input sv32_pte_t exp_pte, input int exp_reads);
    row_names[n_rows]            = name;
    rows[n_rows].vaddr.walk.vpn1 = vpn1;
    rows[n_rows].vaddr.walk.vpn0 = vpn0;
    // offset never reaches the result
    rows[n_rows].vaddr.walk.offset = 12'h5A4;
    rows[n_rows].is_instr    = is_instr;
    rows[n_rows].mode        = mode;
    rows[n_rows].flush_first = flush_first;
    rows[n_rows].exp_pte     = exp_pte;
    rows[n_rows].exp_reads   = 4'(exp_reads);
    n_rows++;
  endtask

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("** Error %s: %s expected 0x%08h, actual 0x%08h", test, what, exp, act);
    abort_run();
  endtask

  task automatic apply_row(input int idx);
    row_t r;
    int   reads_before;
    r = rows[idx];
    @(negedge clk);
    if (r.flush_first) begin
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
    end
    req.vaddr    = r.vaddr;
    req.is_instr = r.is_instr;
    satp.mode    = r.mode;
    satp.asid    = '0;
    satp.ppn     = ROOT_PPN;
    reads_before = read_count;
    valid        = 1'b1;
    // watchdog catches a missing ready_o
    do begin
      @(negedge clk);
    end while (!ready);
    assert (pte === r.exp_pte)
      else report_mismatch(row_names[idx], "pte_o", r.exp_pte, pte);
    assert (read_count - reads_before == int'(r.exp_reads))
      else report_mismatch(row_names[idx], "page table reads", 32'(r.exp_reads),
                           32'(read_count - reads_before));
    valid = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // cycle limit and assertion watch
  initial begin
    cycle_count = 0;
    forever begin
      @(negedge clk);
      cycle_count++;
      if (sv32_mmu_inst.walk_inst.handshake_assert_inst.fail_count != 0) begin
        $display("a handshake assertion on the walker failed");
        abort_run();
      end
      if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        abort_run();
      end
    end
  end

  initial begin
    resetn = 1'b0;
    valid  = 1'b0;
    flush  = 1'b0;
    req    = '0;
    satp   = '0;
    n_rows = 0;
    // name, vpn1, vpn0, instr, mode, flush first, expected pte, reads
    add_row("bare", 10'h048, 10'h345, 1'b0, 1'b0, 1'b0, make_pte(12'h048, 10'h345, 8'h0F), 0);
    add_row("walk_4k", 10'h001, 10'h004, 1'b0, 1'b1, 1'b0, leaf_4k(10'h004), 2);
    add_row("hit_4k", 10'h001, 10'h004, 1'b0, 1'b1, 1'b0, leaf_4k(10'h004), 0);
    add_row("megapage", 10'h002, 10'h155, 1'b0, 1'b1, 1'b0, make_pte(12'h123, 10'h155, 8'hCF), 1);
    add_row("invalid_pte", 10'h003, 10'h010, 1'b0, 1'b1, 1'b0, '0, 1);
    add_row("pointer_l0", 10'h001, 10'h020, 1'b0, 1'b1, 1'b0, '0, 2);
    // same page through both tlbs
    add_row("data_first", 10'h001, 10'h001, 1'b0, 1'b1, 1'b0, leaf_4k(10'h001), 2);
    add_row("instr_first", 10'h001, 10'h001, 1'b1, 1'b1, 1'b0, leaf_4k(10'h001), 2);
    add_row("data_again", 10'h001, 10'h001, 1'b0, 1'b1, 1'b0, leaf_4k(10'h001), 0);
    add_row("instr_again", 10'h001, 10'h001, 1'b1, 1'b1, 1'b0, leaf_4k(10'h001), 0);
    // five pages into dtlb set 0, the fifth overwrites the first
    add_row("flush_walk", 10'h001, 10'h004, 1'b0, 1'b1, 1'b1, leaf_4k(10'h004), 2);
    add_row("set0_fill_b", 10'h001, 10'h008, 1'b0, 1'b1, 1'b0, leaf_4k(10'h008), 2);
    add_row("set0_fill_c", 10'h001, 10'h00C, 1'b0, 1'b1, 1'b0, leaf_4k(10'h00C), 2);
    add_row("set0_fill_d", 10'h001, 10'h010, 1'b0, 1'b1, 1'b0, leaf_4k(10'h010), 2);
    add_row("set0_fill_e", 10'h001, 10'h014, 1'b0, 1'b1, 1'b0, leaf_4k(10'h014), 2);
    add_row("evicted", 10'h001, 10'h004, 1'b0, 1'b1, 1'b0, leaf_4k(10'h004), 2);
    repeat (5) @(negedge clk);
    resetn = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      apply_row(i);
    end
    @(negedge clk);
    if (sv32_mmu_inst.walk_inst.handshake_assert_inst.fail_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("a handshake assertion on the walker failed");
      abort_run();
    end
  end

endmodule
